// ==== hdl/fire_squeeze_pkg.sv ====
`default_nettype none

package fire_squeeze_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////

	// Pixel, weight and output word width
	localparam int WIDTH = 16;
	// Accumulator and bias width
	localparam int ACC_W = 32;

	//////////////////////////////////////////////////////////////////////
	// Lane traffic
	//////////////////////////////////////////////////////////////////////

	// Common per-cycle feed, broadcast to every lane
	typedef struct packed {
		logic signed [WIDTH-1:0] pixel;
		logic                    valid;
		// Channel 0 of a position
		logic                    first;
		// Channel CHIN-1 of a position
		logic                    last;
	} lane_feed_t;

	// One lane's result for one output position
	typedef struct packed {
		logic signed [ACC_W-1:0] sum;
		logic                    done;
	} lane_sum_t;

	// Layer progress, tracked in the output stage
	typedef enum logic [1:0] {
		LAYER_IDLE,
		LAYER_RUN,
		LAYER_DONE
	} layer_state_t;

	//////////////////////////////////////////////////////////////////////
	// Constant weight and bias rules
	//////////////////////////////////////////////////////////////////////

	// Q2.14 weight, tap in -8..7 scaled by 512
	function automatic logic signed [WIDTH-1:0] rom_weight(input int lane, input int channel);
		int tap;
		tap = (lane * 5 + channel * 3) % 16 - 8;
		return WIDTH'(tap * 512);
	endfunction

	// Bias lined up with the Q4.28 accumulator
	function automatic logic signed [ACC_W-1:0] rom_bias(input int lane);
		int scaled;
		scaled = (lane - 3) * (1 << 20);
		return ACC_W'(scaled);
	endfunction

endpackage

`default_nettype wire

// ==== hdl/weight_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module weight_sequencer #(
	parameter int LANES = 8,
	parameter int CHIN  = 8
) (
	input  wire                                           clk,
	input  wire                                           arst_n,
	input  wire                                           layer_en,
	input  wire [fire_squeeze_pkg::WIDTH-1:0]             ifm,
	output fire_squeeze_pkg::lane_feed_t                  feed,
	output logic [LANES-1:0][fire_squeeze_pkg::WIDTH-1:0] kernels
);

	//////////////////////////////////////////////////////////////////////
	// Weight ROM
	//////////////////////////////////////////////////////////////////////

	// Counter width, at least one bit
	localparam int CW = (CHIN > 1) ? $clog2(CHIN) : 1;

	// One ROM row holds the weights of all lanes for one channel
	typedef logic [LANES-1:0][fire_squeeze_pkg::WIDTH-1:0] kernel_row_t;
	typedef kernel_row_t [CHIN-1:0] kernel_rom_t;

	// Fill the table from the package rule at elaboration
	function automatic kernel_rom_t build_rom();
		kernel_rom_t rom;
		for (int c = 0; c < CHIN; c++) begin
			for (int l = 0; l < LANES; l++) begin
				rom[c][l] = fire_squeeze_pkg::rom_weight(l, c);
			end
		end
		return rom;
	endfunction

	localparam kernel_rom_t ROM = build_rom();

	//////////////////////////////////////////////////////////////////////
	// Channel counter
	//////////////////////////////////////////////////////////////////////

	logic [CW-1:0] ch_cnt;
	logic          ch_first;
	logic          ch_last;

	assign ch_first = (ch_cnt == '0);
	assign ch_last  = (ch_cnt == CW'(CHIN - 1));

	// Advances only on enabled cycles, wraps after the last channel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ch_cnt <= '0;
		end else if (layer_en) begin
			if (ch_last)
				ch_cnt <= '0;
			else
				ch_cnt <= ch_cnt + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Lane feed register
	//////////////////////////////////////////////////////////////////////

	logic                                 valid_q;
	logic                                 first_q;
	logic                                 last_q;
	logic [fire_squeeze_pkg::WIDTH-1:0]   pixel_q;

	// Control marks
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
			first_q <= 1'b0;
			last_q  <= 1'b0;
		end else begin
			valid_q <= layer_en;
			first_q <= layer_en && ch_first;
			last_q  <= layer_en && ch_last;
		end
	end

	// Pixel and weights captured together, same cycle as the marks
	always_ff @(posedge clk) begin
		if (layer_en) begin
			pixel_q <= ifm;
			kernels <= ROM[ch_cnt];
		end
	end

	// Pack for the lanes
	assign feed = '{
		pixel: pixel_q,
		valid: valid_q,
		first: first_q,
		last:  last_q
	};

	// Counter stays inside the ROM
	a_ch_cnt_range : assert property (
		@(posedge clk) disable iff (!arst_n)
		ch_cnt <= CW'(CHIN - 1)
	) else $error("channel counter out of range: %0d", ch_cnt);

endmodule

`default_nettype wire

// ==== hdl/mac_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_lane #(
	parameter int CHIN = 8
) (
	input  wire                                       clk,
	input  wire                                       arst_n,
	input  wire fire_squeeze_pkg::lane_feed_t         feed,
	input  wire logic signed [fire_squeeze_pkg::WIDTH-1:0] weight,
	output fire_squeeze_pkg::lane_sum_t               sum
);

	logic signed [fire_squeeze_pkg::ACC_W-1:0] product;
	logic signed [fire_squeeze_pkg::ACC_W-1:0] total;
	logic signed [fire_squeeze_pkg::ACC_W-1:0] acc;
	logic signed [fire_squeeze_pkg::ACC_W-1:0] sum_q;
	logic                                      done_q;

	//////////////////////////////////////////////////////////////////////
	// Multiply and accumulate
	//////////////////////////////////////////////////////////////////////

	// Full-width signed product
	assign product = $signed(feed.pixel) * weight;

	// First channel restarts the running total
	assign total = feed.first ? product : acc + product;

	always_ff @(posedge clk) begin
		if (feed.valid)
			acc <= total;
	end

	//////////////////////////////////////////////////////////////////////
	// Result hand-off
	//////////////////////////////////////////////////////////////////////

	// Held until the next position closes, so the next
	// accumulation overlaps this result
	always_ff @(posedge clk) begin
		if (feed.valid && feed.last)
			sum_q <= total;
	end

	// One-cycle done after the last channel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			done_q <= 1'b0;
		else
			done_q <= feed.valid && feed.last;
	end

	assign sum = '{sum: sum_q, done: done_q};

	// A position spans several channels unless CHIN is 1
	a_first_last : assert property (
		@(posedge clk) disable iff (!arst_n)
		feed.valid && feed.first && feed.last |-> CHIN == 1
	) else $error("first and last on the same feed with CHIN = %0d", CHIN);

endmodule

`default_nettype wire

// ==== hdl/output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_stage #(
	parameter int LANES = 8,
	parameter int NPIX  = 2
) (
	input  wire                                              clk,
	input  wire                                              arst_n,
	input  wire fire_squeeze_pkg::lane_sum_t [LANES-1:0]     sums,
	input  wire                                              ram_feedback,
	output logic [LANES-1:0][fire_squeeze_pkg::WIDTH-1:0]    ofm,
	output logic                                             ofm_sample,
	output logic                                             layer_finish
);

	// Fraction bits dropped by requantization
	localparam int FRAC = 14;
	// Position counter width, at least one bit
	localparam int PW = (NPIX > 1) ? $clog2(NPIX) : 1;

	//////////////////////////////////////////////////////////////////////
	// Bias, ReLU, requantization
	//////////////////////////////////////////////////////////////////////

	logic [LANES-1:0][fire_squeeze_pkg::WIDTH-1:0] ofm_d;

	for (genvar i = 0; i < LANES; i++) begin : g_lane
		localparam logic signed [fire_squeeze_pkg::ACC_W-1:0] BIAS =
			fire_squeeze_pkg::rom_bias(i);
		logic signed [fire_squeeze_pkg::ACC_W-1:0] biased;

		assign biased = sums[i].sum + BIAS;
		// Negative clamps to zero, else keep the integer bit and fraction
		assign ofm_d[i] = biased[fire_squeeze_pkg::ACC_W-1] ? '0 :
			{1'b0, biased[FRAC+fire_squeeze_pkg::WIDTH-2:FRAC]};
	end

	// Output word, only loaded on a result
	always_ff @(posedge clk) begin
		if (sums[0].done)
			ofm <= ofm_d;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ofm_sample <= 1'b0;
		else
			ofm_sample <= sums[0].done;
	end

	//////////////////////////////////////////////////////////////////////
	// Layer progress
	//////////////////////////////////////////////////////////////////////

	fire_squeeze_pkg::layer_state_t state;
	logic [PW-1:0]                  pos_cnt;
	logic                           fb_seen;

	// Counts samples, so layer_finish follows the last one by a cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= fire_squeeze_pkg::LAYER_IDLE;
			pos_cnt <= '0;
		end else begin
			unique case (state)
				fire_squeeze_pkg::LAYER_IDLE,
				fire_squeeze_pkg::LAYER_RUN: begin
					if (ofm_sample) begin
						if (pos_cnt == PW'(NPIX - 1)) begin
							state <= fire_squeeze_pkg::LAYER_DONE;
						end else begin
							state   <= fire_squeeze_pkg::LAYER_RUN;
							pos_cnt <= pos_cnt + 1'b1;
						end
					end
				end
				// Stays here until reset
				default: state <= fire_squeeze_pkg::LAYER_DONE;
			endcase
		end
	end

	// Feedback latched, even an early one
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			fb_seen <= 1'b0;
		else if (ram_feedback)
			fb_seen <= 1'b1;
	end

	assign layer_finish = (state == fire_squeeze_pkg::LAYER_DONE) && !fb_seen;

	// Lanes run in lock step
	for (genvar i = 1; i < LANES; i++) begin : g_done_chk
		a_done_equal : assert property (
			@(posedge clk) disable iff (!arst_n)
			sums[i].done == sums[0].done
		) else $error("lane %0d done differs from lane 0", i);
	end

	// More results than positions
	a_no_late_done : assert property (
		@(posedge clk) disable iff (!arst_n)
		sums[0].done |-> state != fire_squeeze_pkg::LAYER_DONE
	) else $error("result arrived after the layer finished");

endmodule

`default_nettype wire

// ==== hdl/fire_squeeze_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fire_squeeze_layer #(
	parameter int LANES = 8,
	parameter int CHIN  = 8,
	parameter int NPIX  = 2
) (
	input  wire                                           clk,
	input  wire                                           arst_n,
	input  wire                                           layer_en,
	input  wire [fire_squeeze_pkg::WIDTH-1:0]             ifm,
	input  wire                                           ram_feedback,
	output wire [LANES-1:0][fire_squeeze_pkg::WIDTH-1:0]  ofm,
	output wire                                           ofm_sample,
	output wire                                           layer_finish
);

	//////////////////////////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////////////////////////

	// Broadcast feed and per-lane weights
	wire fire_squeeze_pkg::lane_feed_t                     feed;
	wire [LANES-1:0][fire_squeeze_pkg::WIDTH-1:0]          kernels;
	// One result per lane
	wire fire_squeeze_pkg::lane_sum_t [LANES-1:0]          sums;

	//////////////////////////////////////////////////////////////////////
	// Pipeline
	//////////////////////////////////////////////////////////////////////

	// Stage 1, pixel and weights aligned
	weight_sequencer #(
		.LANES (LANES),
		.CHIN  (CHIN)
	) weight_sequencer_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.layer_en (layer_en),
		.ifm      (ifm),
		.feed     (feed),
		.kernels  (kernels)
	);

	// Stage 2, one output channel per lane
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		mac_lane #(
			.CHIN (CHIN)
		) mac_lane_inst (
			.clk    (clk),
			.arst_n (arst_n),
			.feed   (feed),
			.weight (kernels[i]),
			.sum    (sums[i])
		);
	end

	// Stage 3, bias, ReLU, layer end
	output_stage #(
		.LANES (LANES),
		.NPIX  (NPIX)
	) output_stage_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.sums         (sums),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.ofm_sample   (ofm_sample),
		.layer_finish (layer_finish)
	);

endmodule

`default_nettype wire

// ==== tests/fire_squeeze_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module fire_squeeze_checker #(
	parameter int LANES = 8,
	parameter int CHIN  = 8,
	parameter int NPIX  = 2
) (
	input  wire                                                    clk,
	input  wire                                                    arst_n,
	input  wire                                                    layer_en,
	input  wire                                                    ram_feedback,
	input  wire [LANES-1:0][fire_squeeze_pkg::WIDTH-1:0]           ofm,
	input  wire                                                    ofm_sample,
	input  wire                                                    layer_finish,
	input  wire [NPIX-1:0][LANES-1:0][fire_squeeze_pkg::WIDTH-1:0] expected,
	output int                                                     mismatch_count,
	output int                                                     fault_count,
	output int                                                     sample_count
);

	// Edges from an enabled last channel to its sample
	localparam int LATENCY = 3;

	int cycle;
	int chan;
	// Edge numbers of last channels still waiting for a sample
	int last_q[$];
	// Expected layer_finish model
	bit done_m;
	bit fb_m;

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	// Finish high after NPIX samples, until feedback
	task automatic check_finish();
		logic exp_finish;
		exp_finish = done_m && !fb_m;
		if (layer_finish !== exp_finish) begin
			mismatch_count++;
			$display("Mismatch test=layer_finish_edge%0d expected=%0b actual=%0b",
				cycle, exp_finish, layer_finish);
		end
	endtask

	task automatic track_channel();
		if (chan == CHIN - 1) begin
			last_q.push_back(cycle);
			chan = 0;
		end else begin
			chan++;
		end
	endtask

	task automatic check_sample();
		int start;
		int pos;
		pos = sample_count;
		sample_count++;
		// Strobe with nothing pending, e.g. right after reset
		if (last_q.size() == 0) begin
			fault_count++;
			$display("ofm_sample at edge %0d with no position completed", cycle);
		end else begin
			start = last_q.pop_front();
			if (cycle - start != LATENCY) begin
				fault_count++;
				$display("Mismatch test=latency_sample%0d expected=%0d actual=%0d",
					pos, LATENCY, cycle - start);
			end
		end
		if (pos >= NPIX) begin
			fault_count++;
			$display("extra ofm_sample, number %0d of %0d", pos + 1, NPIX);
		end else begin
			for (int l = 0; l < LANES; l++) begin
				if (ofm[l] !== expected[pos][l]) begin
					mismatch_count++;
					$display("Mismatch test=pos%0d_lane%0d expected=0x%04h actual=0x%04h",
						pos, l, expected[pos][l], ofm[l]);
				end
			end
			if (pos == NPIX - 1)
				done_m = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Watcher
	//////////////////////////////////////////////////////////////////////

	// Everything sampled at the rising edge, before the DUT updates
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle          = 0;
			chan           = 0;
			last_q.delete();
			done_m         = 1'b0;
			fb_m           = 1'b0;
			mismatch_count = 0;
			fault_count    = 0;
			sample_count   = 0;
		end else begin
			cycle++;
			check_finish();
			if (layer_en)
				track_channel();
			if (ofm_sample)
				check_sample();
			// Clears finish from the next cycle on, also when early
			if (ram_feedback)
				fb_m = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_fire_squeeze.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fire_squeeze;

	localparam int LANES   = 8;
	localparam int CHIN    = 8;
	localparam int NPIX    = 2;
	localparam int WIDTH   = fire_squeeze_pkg::WIDTH;
	// Pixels first, then expected words
	localparam int NPIXELS = NPIX * CHIN;
	localparam int NWORDS  = NPIXELS + NPIX * LANES;
	// Edges allowed for any one wait
	localparam int WAIT_LIMIT = 200;

	logic                          clk;
	logic                          arst_n;
	logic                          layer_en;
	logic                          ram_feedback;
	logic [WIDTH-1:0]              ifm;
	wire  [LANES-1:0][WIDTH-1:0]   ofm;
	wire                           ofm_sample;
	wire                           layer_finish;

	logic [31:0]                          vec_mem [0:NWORDS-1];
	logic [NPIX-1:0][LANES-1:0][WIDTH-1:0] expected;
	int                                   mismatch_count;
	int                                   fault_count;
	int                                   sample_count;
	int                                   tb_fault_count;
	int                                   seed_ret;
	bit                                   wait_ok;

	//////////////////////////////////////////////////////////////////////
	// DUT and checker
	//////////////////////////////////////////////////////////////////////

	fire_squeeze_layer #(
		.LANES (LANES),
		.CHIN  (CHIN),
		.NPIX  (NPIX)
	) fire_squeeze_layer_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.layer_en     (layer_en),
		.ifm          (ifm),
		.ram_feedback (ram_feedback),
		.ofm          (ofm),
		.ofm_sample   (ofm_sample),
		.layer_finish (layer_finish)
	);

	fire_squeeze_checker #(
		.LANES (LANES),
		.CHIN  (CHIN),
		.NPIX  (NPIX)
	) fire_squeeze_checker_inst (
		.clk            (clk),
		.arst_n         (arst_n),
		.layer_en       (layer_en),
		.ram_feedback   (ram_feedback),
		.ofm            (ofm),
		.ofm_sample     (ofm_sample),
		.layer_finish   (layer_finish),
		.expected       (expected),
		.mismatch_count (mismatch_count),
		.fault_count    (fault_count),
		.sample_count   (sample_count)
	);

	// 4 ns period
	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// Upper half of the fill, never set by the file, marks unloaded words
	task automatic load_vectors();
		for (int i = 0; i < NWORDS; i++)
			vec_mem[i] = 32'hbad0_0000 | 32'(i);
		$readmemh("tests/fire_squeeze_vectors.hex", vec_mem);
		for (int i = 0; i < NWORDS; i++) begin
			if (vec_mem[i][31:16] != 16'h0000) begin
				tb_fault_count++;
				$display("vector file missing or short at word %0d", i);
				break;
			end
		end
		for (int p = 0; p < NPIX; p++)
			for (int l = 0; l < LANES; l++)
				expected[p][l] = vec_mem[NPIXELS + p * LANES + l][WIDTH-1:0];
	endtask

	// Idle cycles carry junk on ifm that the DUT must ignore
	task automatic drive_pixel(input logic [WIDTH-1:0] px, input int gap);
		repeat (gap) begin
			@(posedge clk);
			layer_en <= 1'b0;
			ifm      <= WIDTH'($urandom);
		end
		@(posedge clk);
		layer_en <= 1'b1;
		ifm      <= px;
	endtask

	task automatic pulse_feedback();
		@(posedge clk);
		ram_feedback <= 1'b1;
		@(posedge clk);
		ram_feedback <= 1'b0;
	endtask

	// Bounded poll of layer_finish for a level
	task automatic wait_finish_level(input logic level, input int limit, output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < limit) begin
			@(posedge clk);
			if (layer_finish === level)
				ok = 1'b1;
			n++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk            = 1'b0;
		arst_n         = 1'b0;
		layer_en       = 1'b0;
		ram_feedback   = 1'b0;
		ifm            = '0;
		tb_fault_count = 0;
		seed_ret       = $urandom(32'h7a61);
		load_vectors();

		repeat (10) @(posedge clk);
		arst_n <= 1'b1;

		// Channel by channel, position after position
		for (int p = 0; p < NPIXELS; p++)
			drive_pixel(vec_mem[p][WIDTH-1:0], $urandom_range(0, 3));
		@(posedge clk);
		layer_en <= 1'b0;

		wait_finish_level(1'b1, WAIT_LIMIT, wait_ok);
		if (!wait_ok) begin
			tb_fault_count++;
			$display("timeout: layer_finish never rose");
		end

		// Finish must hold while the RAM stays silent
		repeat (6) @(posedge clk);
		pulse_feedback();

		wait_finish_level(1'b0, WAIT_LIMIT, wait_ok);
		if (!wait_ok) begin
			tb_fault_count++;
			$display("timeout: layer_finish did not fall after ram_feedback");
		end

		// Must stay low from here on
		repeat (8) @(posedge clk);
		@(negedge clk);
		if (sample_count != NPIX) begin
			tb_fault_count++;
			$display("Mismatch test=sample_count expected=%0d actual=%0d",
				NPIX, sample_count);
		end

		$display("errors: %0d mismatches, %0d checker faults, %0d testbench faults",
			mismatch_count, fault_count, tb_fault_count);
		if (mismatch_count + fault_count + tb_fault_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/fire_squeeze_vectors.hex ====
// Words 0..15: ifm pixels, position 0 then 1, channel 0..7 in the low 16 bits
// Words 16..31: expected ofm, position 0 then 1, lane 0..7 in the low 16 bits
00000150
0000ff80
000000c0
00000060
0000ff00
000000a0
00000040
0000ffe0
0000fd80
0000fec0
00000080
00000180
000001e0
00000240
0000ff40
00000128
00000000
00000000
00000000
0000004b
00000057
000000aa
000000fe
00000089
000000d8
00000000
00000000
00000042
00000021
00000010
000000eb
000001bb

// ==== files.f ====
hdl/fire_squeeze_pkg.sv
hdl/weight_sequencer.sv
hdl/mac_lane.sv
hdl/output_stage.sv
hdl/fire_squeeze_layer.sv
tests/fire_squeeze_checker.sv
tests/tb_fire_squeeze.sv

// ==== Makefile ====
# Verilator flow for the fire squeeze layer testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       := tb_fire_squeeze
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
